// File: common/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// decode lanes presenting a pc each cycle
`define FETCH_DECODE_PARA 2

// words per line is 2**FETCH_LOG_PARA
`define FETCH_LOG_PARA 1
`define FETCH_PARA (1 << `FETCH_LOG_PARA)

`define FETCH_LINE_ADDR_W 8
`define FETCH_WORD_W 32

// line cache entries
`define FETCH_CACHE_DEPTH 8

// prefetch window covers the base line and the lines after it
`define FETCH_PREDICT_SIZE 5

`endif

// File: common/fetch_pkg.sv
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    // byte address
    // [1:0] ignored, then word offset, then line address
    typedef logic [31:0] pc_t;

    typedef logic [`FETCH_WORD_W-1:0] instr_t;

    // one bit per decode lane
    typedef logic [`FETCH_DECODE_PARA-1:0] lane_mask_t;

endpackage

`default_nettype wire

// File: common/imem_pkg.sv
`default_nettype none

`include "fetch_config.svh"

package imem_pkg;

    typedef logic [`FETCH_LINE_ADDR_W-1:0] line_addr_t;

    // word 0 in the highest slice
    typedef logic [`FETCH_PARA*`FETCH_WORD_W-1:0] line_t;

    // bit FETCH_PARA-1 enables word 0
    typedef logic [`FETCH_PARA-1:0] wen_t;

endpackage

`default_nettype wire

// File: common/cache_lookup_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_lookup_if #(
    parameter int N = 1
);

    logic [N-1:0]                  order;
    imem_pkg::line_addr_t [N-1:0]  key;
    logic [N-1:0]                  hit;
    imem_pkg::line_t [N-1:0]       line;

    modport requester (
        output order,
        output key,
        input  hit,
        input  line
    );

    modport cache (
        input  order,
        input  key,
        output hit,
        output line
    );

endinterface

`default_nettype wire

// File: fetch/fetch_timing.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_timing #(
    parameter int FIND_PARA = 1
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 access_order,
    input  imem_pkg::line_addr_t                 access_addr,
    input  imem_pkg::line_addr_t [FIND_PARA-1:0] find_addr,
    output logic                                 access_done,
    output imem_pkg::line_addr_t                 accessed_addr,
    output logic [FIND_PARA-1:0]                 found
);

    // stage 0 is the issuing cycle itself
    logic                 stage1;
    logic                 stage2;
    imem_pkg::line_addr_t addr1;
    imem_pkg::line_addr_t addr2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage1 <= 1'b0;
            stage2 <= 1'b0;
        end else begin
            stage1 <= access_order;
            stage2 <= stage1;
        end
    end

    always_ff @(posedge clk) begin
        addr1 <= access_addr;
        addr2 <= addr1;
    end

    assign access_done   = stage2;
    assign accessed_addr = addr2;

    // anything in flight counts, so no line is requested twice
    for (genvar i = 0; i < FIND_PARA; i++) begin : g_find
        assign found[i] = (access_order && find_addr[i] == access_addr)
                        | (stage1 && find_addr[i] == addr1)
                        | (stage2 && find_addr[i] == addr2);
    end

endmodule

`default_nettype wire

// File: fetch/line_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module line_cache #(
    parameter int DEPTH   = `FETCH_CACHE_DEPTH,
    parameter int LANE_N  = `FETCH_DECODE_PARA,
    parameter int PROBE_N = `FETCH_PREDICT_SIZE + 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fill_valid,
    input  imem_pkg::line_addr_t fill_key,
    input  imem_pkg::line_t      fill_line,
    cache_lookup_if.cache        lanes,
    cache_lookup_if.cache        probes
);

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int LINE_W = $bits(imem_pkg::line_t);

    logic [DEPTH-1:0]     valid;
    imem_pkg::line_addr_t tag  [DEPTH];
    imem_pkg::line_t      data [DEPTH];
    logic [PTR_W-1:0]     rr_ptr;
    logic                 resident;
    logic [PTR_W-1:0]     resident_idx;
    logic [PTR_W-1:0]     wr_idx;

    // {hit, line} for one key against every valid tag
    function automatic logic [LINE_W:0] lookup(input imem_pkg::line_addr_t key);
        logic [LINE_W:0] res;
        res = '0;
        for (int e = 0; e < DEPTH; e++) begin
            if (valid[e] && tag[e] == key) begin
                res = {1'b1, data[e]};
            end
        end
        return res;
    endfunction

    always_comb begin
        resident     = 1'b0;
        resident_idx = '0;
        for (int e = 0; e < DEPTH; e++) begin
            if (valid[e] && tag[e] == fill_key) begin
                resident     = 1'b1;
                resident_idx = PTR_W'(e);
            end
        end
    end

    // a line already held is rewritten in place
    assign wr_idx = resident ? resident_idx : rr_ptr;

    // the entry write is the single register stage on the fill path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else if (fill_valid) begin
            valid[wr_idx] <= 1'b1;
            if (!resident) begin
                rr_ptr <= (rr_ptr == PTR_W'(DEPTH - 1)) ? '0 : rr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag[wr_idx]  <= fill_key;
            data[wr_idx] <= fill_line;
        end
    end

    for (genvar p = 0; p < LANE_N; p++) begin : g_lane
        logic [LINE_W:0] res;
        always_comb begin
            res = lookup(lanes.key[p]);
        end
        assign lanes.hit[p]  = lanes.order[p] & res[LINE_W];
        assign lanes.line[p] = res[LINE_W-1:0];
    end

    // probes always search
    for (genvar p = 0; p < PROBE_N; p++) begin : g_probe
        logic [LINE_W:0] res;
        always_comb begin
            res = lookup(probes.key[p]);
        end
        assign probes.hit[p]  = res[LINE_W];
        assign probes.line[p] = res[LINE_W-1:0];
    end

endmodule

`default_nettype wire

// File: fetch/fetch_predict.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_predict (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  fetch_pkg::lane_mask_t                         lane_order,
    input  fetch_pkg::lane_mask_t                         lane_hit,
    input  imem_pkg::line_addr_t [`FETCH_DECODE_PARA-1:0] lane_key,
    input  fetch_pkg::pc_t                                lr,
    input  logic                                          load_mode,
    input  fetch_pkg::pc_t                                load_pc,
    cache_lookup_if.requester                             probe,
    input  logic [`FETCH_PREDICT_SIZE:0]                  found,
    output logic                                          access_order,
    output imem_pkg::line_addr_t                          access_addr
);

    localparam int LANES    = `FETCH_DECODE_PARA;
    localparam int WIN      = `FETCH_PREDICT_SIZE;
    localparam int LINE_LSB = `FETCH_LOG_PARA + 2;

    imem_pkg::line_addr_t           lr_line;
    imem_pkg::line_addr_t           load_line;
    imem_pkg::line_addr_t           last_found;
    imem_pkg::line_addr_t           next_last_found;
    imem_pkg::line_addr_t           fail_addr;
    imem_pkg::line_addr_t           base;
    imem_pkg::line_addr_t           cand;
    imem_pkg::line_addr_t           next_addr;
    imem_pkg::line_addr_t [WIN-1:0] win_addr;
    logic                           find_failure;
    logic                           gap_stop;
    logic                           lr_open;
    logic                           next_order;
    logic [WIN-1:0]                 win_open;

    assign lr_line   = lr[LINE_LSB +: `FETCH_LINE_ADDR_W];
    assign load_line = load_pc[LINE_LSB +: `FETCH_LINE_ADDR_W];

    always_comb begin
        find_failure    = 1'b0;
        fail_addr       = lane_key[0];
        next_last_found = last_found;
        gap_stop        = ~lane_order[0];
        // lowest missing lane wins
        for (int i = LANES - 1; i >= 0; i--) begin
            if (lane_order[i] && !lane_hit[i]) begin
                find_failure = 1'b1;
                fail_addr    = lane_key[i];
            end
        end
        // highest hitting lane wins
        for (int i = 0; i < LANES; i++) begin
            if (lane_order[i] && lane_hit[i]) begin
                next_last_found = lane_key[i];
            end
        end
        // lane idle right after a hit means the stream stopped
        for (int i = 1; i < LANES; i++) begin
            gap_stop = gap_stop | (~lane_order[i] & lane_hit[i-1]);
        end
    end

    assign base = find_failure ? fail_addr : next_last_found;

    for (genvar k = 0; k < WIN; k++) begin : g_win
        assign win_addr[k]  = base + imem_pkg::line_addr_t'(k);
        assign probe.key[k] = win_addr[k];
        assign win_open[k]  = ~(probe.hit[k] | found[k]);
    end

    // last probe slot is the link register line
    assign probe.key[WIN] = lr_line;
    assign probe.order    = '1;
    assign lr_open        = ~(probe.hit[WIN] | found[WIN]);

    always_comb begin
        cand = win_addr[0];
        for (int k = WIN - 1; k >= 0; k--) begin
            if (win_open[k]) begin
                cand = win_addr[k];
            end
        end
    end

    assign next_order = ~load_mode & ((|win_open) | (lr_open & gap_stop));

    always_comb begin
        if (load_mode) begin
            next_addr = load_line;
        end else if (|win_open) begin
            next_addr = cand;
        end else begin
            next_addr = lr_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            access_order <= 1'b0;
            last_found   <= '0;
        end else begin
            access_order <= next_order;
            last_found   <= next_last_found;
        end
    end

    always_ff @(posedge clk) begin
        access_addr <= next_addr;
    end

endmodule

`default_nettype wire

// File: fetch/fetch_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_port (
    input  fetch_pkg::lane_mask_t                    order,
    input  fetch_pkg::pc_t [`FETCH_DECODE_PARA-1:0]  pc,
    output fetch_pkg::lane_mask_t                    done,
    output fetch_pkg::instr_t [`FETCH_DECODE_PARA-1:0] instr,
    cache_lookup_if.requester                        lookup
);

    localparam int LANES    = `FETCH_DECODE_PARA;
    localparam int PARA     = `FETCH_PARA;
    localparam int W        = `FETCH_WORD_W;
    localparam int LOG      = `FETCH_LOG_PARA;
    localparam int OFF_W    = (LOG > 0) ? LOG : 1;
    localparam int LINE_LSB = LOG + 2;

    assign lookup.order = order;
    assign done         = lookup.hit;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        fetch_pkg::instr_t words [PARA];
        logic [OFF_W-1:0]  word_off;

        assign lookup.key[i] = pc[i][LINE_LSB +: `FETCH_LINE_ADDR_W];

        // one word per line has no offset bits
        assign word_off = (LOG > 0) ? pc[i][2 +: OFF_W] : '0;

        // word 0 sits in the top slice
        for (genvar j = 0; j < PARA; j++) begin : g_word
            assign words[j] = lookup.line[i][(PARA-1-j)*W +: W];
        end

        assign instr[i] = words[word_off];
    end

endmodule

`default_nettype wire

// File: logic/load_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module load_writer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_mode,
    input  logic              load_valid,
    input  fetch_pkg::pc_t    load_pc,
    input  fetch_pkg::instr_t load_data,
    output imem_pkg::wen_t    mem_wen,
    output imem_pkg::line_t   mem_wdata
);

    localparam int PARA  = `FETCH_PARA;
    localparam int W     = `FETCH_WORD_W;
    localparam int LOG   = `FETCH_LOG_PARA;
    localparam int OFF_W = (LOG > 0) ? LOG : 1;

    imem_pkg::wen_t    next_wen;
    fetch_pkg::instr_t data_q;
    logic [OFF_W-1:0]  word_off;

    assign word_off = (LOG > 0) ? load_pc[2 +: OFF_W] : '0;

    // word i enables bit PARA-1-i
    always_comb begin
        for (int i = 0; i < PARA; i++) begin
            next_wen[PARA-1-i] = load_mode & load_valid & (word_off == OFF_W'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wen <= '0;
        end else begin
            mem_wen <= next_wen;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= load_data;
    end

    for (genvar i = 0; i < PARA; i++) begin : g_slice
        assign mem_wdata[i*W +: W] = mem_wen[i] ? data_q : '0;
    end

endmodule

`default_nettype wire

// File: fetch/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  fetch_pkg::lane_mask_t                      order,
    input  fetch_pkg::pc_t [`FETCH_DECODE_PARA-1:0]    pc,
    output fetch_pkg::lane_mask_t                      done,
    output fetch_pkg::instr_t [`FETCH_DECODE_PARA-1:0] instr,
    input  fetch_pkg::pc_t                             lr,
    output logic                                       mem_read,
    output imem_pkg::line_addr_t                       mem_addr,
    input  imem_pkg::line_t                            mem_rdata,
    output imem_pkg::wen_t                             mem_wen,
    output imem_pkg::line_t                            mem_wdata,
    input  logic                                       load_mode,
    input  logic                                       load_valid,
    input  fetch_pkg::pc_t                             load_pc,
    input  fetch_pkg::instr_t                          load_data
);

    localparam int PROBE_N = `FETCH_PREDICT_SIZE + 1;

    logic                   access_order;
    imem_pkg::line_addr_t   access_addr;
    logic                   access_done;
    imem_pkg::line_addr_t   accessed_addr;
    logic [PROBE_N-1:0]     found;

    cache_lookup_if #(.N(`FETCH_DECODE_PARA)) lane_if ();
    cache_lookup_if #(.N(PROBE_N)) probe_if ();

    fetch_port port_i (
        .order  (order),
        .pc     (pc),
        .done   (done),
        .instr  (instr),
        .lookup (lane_if.requester)
    );

    line_cache cache_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_valid (access_done),
        .fill_key   (accessed_addr),
        .fill_line  (mem_rdata),
        .lanes      (lane_if.cache),
        .probes     (probe_if.cache)
    );

    // lane signals tapped for miss detection
    fetch_predict predict_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_order   (lane_if.order),
        .lane_hit     (lane_if.hit),
        .lane_key     (lane_if.key),
        .lr           (lr),
        .load_mode    (load_mode),
        .load_pc      (load_pc),
        .probe        (probe_if.requester),
        .found        (found),
        .access_order (access_order),
        .access_addr  (access_addr)
    );

    fetch_timing #(.FIND_PARA(PROBE_N)) timing_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .access_order  (access_order),
        .access_addr   (access_addr),
        .find_addr     (probe_if.key),
        .access_done   (access_done),
        .accessed_addr (accessed_addr),
        .found         (found)
    );

    load_writer writer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_mode  (load_mode),
        .load_valid (load_valid),
        .load_pc    (load_pc),
        .load_data  (load_data),
        .mem_wen    (mem_wen),
        .mem_wdata  (mem_wdata)
    );

    assign mem_read = access_order;
    assign mem_addr = access_addr;

endmodule

`default_nettype wire

// File: verification/imem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module imem_model (
    input  logic                 clk,
    input  logic                 mem_read,
    input  imem_pkg::line_addr_t mem_addr,
    output imem_pkg::line_t      mem_rdata,
    input  imem_pkg::wen_t       mem_wen,
    input  imem_pkg::line_t      mem_wdata
);

    localparam int LINES = 1 << `FETCH_LINE_ADDR_W;
    localparam int PARA  = `FETCH_PARA;
    localparam int W     = `FETCH_WORD_W;

    imem_pkg::line_t      mem [LINES] = '{default: '0};
    imem_pkg::line_addr_t addr_q = '0;
    logic                 read_q = 1'b0;

    // address taken at the first edge, data out after the second
    always @(posedge clk) begin
        read_q <= mem_read;
        addr_q <= mem_addr;
        if (read_q) begin
            mem_rdata <= mem[addr_q];
        end
    end

    // enable bit k writes slice k
    always @(posedge clk) begin
        for (int k = 0; k < PARA; k++) begin
            if (mem_wen[k]) begin
                mem[mem_addr][k*W +: W] <= mem_wdata[k*W +: W];
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_config.svh"

module fetch_tb;

    localparam int LANES      = `FETCH_DECODE_PARA;
    localparam int PARA       = `FETCH_PARA;
    localparam int W          = `FETCH_WORD_W;
    localparam int LINES      = 1 << `FETCH_LINE_ADDR_W;
    localparam int PROG_WORDS = 64;
    localparam int TIMEOUT    = 100;

    logic                           clk = 1'b0;
    logic                           rst_n;
    fetch_pkg::lane_mask_t          order;
    fetch_pkg::pc_t [LANES-1:0]     pc;
    fetch_pkg::lane_mask_t          done;
    fetch_pkg::instr_t [LANES-1:0]  instr;
    fetch_pkg::pc_t                 lr;
    logic                           mem_read;
    imem_pkg::line_addr_t           mem_addr;
    imem_pkg::line_t                mem_rdata;
    imem_pkg::wen_t                 mem_wen;
    imem_pkg::line_t                mem_wdata;
    logic                           load_mode;
    logic                           load_valid;
    fetch_pkg::pc_t                 load_pc;
    fetch_pkg::instr_t              load_data;

    fetch_pkg::instr_t prog [PROG_WORDS];
    logic [15:0]       lfsr_state;
    int                errors;
    int                checks;
    int                timeouts;
    logic              recording;
    int                read_count [LINES];

    always #50 clk = ~clk;

    fetch_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .order      (order),
        .pc         (pc),
        .done       (done),
        .instr      (instr),
        .lr         (lr),
        .mem_read   (mem_read),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_wen    (mem_wen),
        .mem_wdata  (mem_wdata),
        .load_mode  (load_mode),
        .load_valid (load_valid),
        .load_pc    (load_pc),
        .load_data  (load_data)
    );

    imem_model mem_i (
        .clk       (clk),
        .mem_read  (mem_read),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_wen   (mem_wen),
        .mem_wdata (mem_wdata)
    );

    // one count per cycle with a read issued
    always @(negedge clk) begin
        if (recording && mem_read) begin
            read_count[mem_addr] = read_count[mem_addr] + 1;
        end
    end

    // galois step with the taps of a maximal 16 bit sequence
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic random_word(output fetch_pkg::instr_t w);
        w = '0;
        for (int b = 0; b < W; b++) begin
            w = {w[W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic fetch_pkg::pc_t word_pc(input int word);
        return fetch_pkg::pc_t'(word) << 2;
    endfunction

    // word 0 in the top slice
    function automatic imem_pkg::line_t expected_line(input int l);
        imem_pkg::line_t v;
        v = '0;
        for (int j = 0; j < PARA; j++) begin
            v[(PARA-1-j)*W +: W] = prog[l*PARA + j];
        end
        return v;
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        order <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // quiet means several cycles in a row without a read
    task automatic wait_quiet();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 8 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            quiet = mem_read ? 0 : quiet + 1;
        end
        if (quiet < 8) begin
            timeouts++;
            $display("timeout: memory reads never stopped");
        end
    endtask

    task automatic wait_line_read(input int line, input string what);
        int   n;
        logic seen;
        seen = 1'b0;
        n = 0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            seen = mem_read && (mem_addr == imem_pkg::line_addr_t'(line));
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: the %s line was never read", what);
        end
    endtask

    task automatic fetch_one(input int word, output int wait_cycles);
        @(posedge clk);
        order <= fetch_pkg::lane_mask_t'(1);
        pc[0] <= word_pc(word);
        @(negedge clk);
        wait_cycles = 0;
        while (!done[0] && wait_cycles < TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (done[0]) begin
            check_equal("lane 0 instr", 64'(instr[0]), 64'(prog[word]));
        end else begin
            timeouts++;
            $display("timeout: lane 0 never saw done for word %0d", word);
        end
        @(posedge clk);
        order <= '0;
    endtask

    task automatic reset_state();
        int n;
        apply_reset();
        @(negedge clk);
        check_equal("done after reset", 64'(done), 64'(0));
        check_equal("mem_read after reset", 64'(mem_read), 64'(0));
        check_equal("mem_wen after reset", 64'(mem_wen), 64'(0));
        n = 0;
        while (!mem_read && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!mem_read) begin
            timeouts++;
            $display("timeout: no prefetch read after reset");
        end
    endtask

    task automatic program_load();
        int o;
        @(posedge clk);
        load_mode <= 1'b1;
        // lets the last read decision drain
        @(posedge clk);
        for (int n = 0; n < PROG_WORDS; n++) begin
            o = n % PARA;
            load_valid <= 1'b1;
            load_pc    <= word_pc(n);
            load_data  <= prog[n];
            @(posedge clk);
            load_valid <= 1'b0;
            @(negedge clk);
            check_equal("mem_wen", 64'(mem_wen), 64'(1) << (PARA - 1 - o));
            check_equal("mem_wdata", 64'(mem_wdata), 64'(prog[n]) << ((PARA - 1 - o) * W));
            check_equal("mem_addr on load", 64'(mem_addr), 64'(n / PARA));
            check_equal("mem_read in load mode", 64'(mem_read), 64'(0));
            @(posedge clk);
        end
        load_mode <= 1'b0;
        @(negedge clk);
        for (int l = 0; l < PROG_WORDS / PARA; l++) begin
            check_equal($sformatf("memory line %0d", l), 64'(mem_i.mem[l]),
                        64'(expected_line(l)));
        end
        @(posedge clk);
    endtask

    task automatic miss_then_hit();
        int cycles;
        fetch_one(20 * PARA + 1, cycles);
        check_equal("lane 0 missed first", 64'(cycles > 0), 64'(1));
    endtask

    task automatic two_lane_fetch();
        int                    words [LANES];
        int                    n;
        fetch_pkg::lane_mask_t seen;
        words[0] = 10 * PARA;
        words[1] = 27 * PARA + 1;
        seen = '0;
        n = 0;
        @(posedge clk);
        order <= '1;
        pc[0] <= word_pc(words[0]);
        pc[1] <= word_pc(words[1]);
        while (seen != '1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            for (int i = 0; i < LANES; i++) begin
                if (done[i] && !seen[i]) begin
                    check_equal($sformatf("lane %0d instr", i), 64'(instr[i]),
                                64'(prog[words[i]]));
                    seen[i] = 1'b1;
                end
            end
        end
        if (seen != '1) begin
            timeouts++;
            $display("timeout: not every lane saw done with two lanes ordering");
        end
        @(posedge clk);
        order <= '0;
    endtask

    task automatic window_prefetch();
        int a;
        int cycles;
        a = 5;
        wait_quiet();
        // the lr probe brings line a in while the window sits elsewhere
        @(posedge clk);
        lr <= word_pc(a * PARA);
        wait_line_read(a, "window base");
        wait_quiet();
        @(posedge clk);
        for (int l = 0; l < LINES; l++) begin
            read_count[l] = 0;
        end
        recording = 1'b1;
        fetch_one(a * PARA, cycles);
        check_equal($sformatf("line %0d hits at once", a), 64'(cycles), 64'(0));
        wait_quiet();
        recording = 1'b0;
        for (int k = 1; k < 5; k++) begin
            check_equal($sformatf("reads of line %0d", a + k), 64'(read_count[a + k]), 64'(1));
        end
        for (int l = 0; l < LINES; l++) begin
            check_equal($sformatf("line %0d read twice", l), 64'(read_count[l] > 1), 64'(0));
        end
    endtask

    task automatic link_register_read();
        int w;
        int cycles;
        w = 25 * PARA + 1;
        @(posedge clk);
        lr <= word_pc(w);
        wait_line_read(w / PARA, "link register");
        wait_quiet();
        fetch_one(w, cycles);
        check_equal("lr line hits at once", 64'(cycles), 64'(0));
    endtask

    initial begin
        rst_n      = 1'b0;
        order      = '0;
        pc         = '0;
        lr         = '0;
        load_mode  = 1'b0;
        load_valid = 1'b0;
        load_pc    = '0;
        load_data  = '0;
        recording  = 1'b0;
        errors     = 0;
        checks     = 0;
        timeouts   = 0;
        lfsr_state = 16'd88;
        for (int n = 0; n < PROG_WORDS; n++) begin
            random_word(prog[n]);
        end

        reset_state();
        program_load();
        // no invalidation, so stale lines go with a reset
        apply_reset();
        miss_then_hit();
        two_lane_fetch();
        window_prefetch();
        link_register_read();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/fetch_pkg.sv
common/imem_pkg.sv
common/cache_lookup_if.sv
fetch/fetch_timing.sv
fetch/line_cache.sv
fetch/fetch_predict.sv
fetch/fetch_port.sv
logic/load_writer.sv
fetch/fetch_top.sv
verification/imem_model.sv
verification/fetch_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module fetch_tb \
    -f project.f \
    -o fetch_sim

out=$(./obj_dir/fetch_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
